/* design/adam_axil_pkg.sv */
package adam_axil_pkg;

    // bus geometry
    localparam int unsigned ADDR_WIDTH = 32;
    localparam int unsigned DATA_WIDTH = 32;

    // one strobe bit per byte lane
    localparam int unsigned STRB_WIDTH = DATA_WIDTH / 8;

    // low address bits that select a byte within a word
    localparam int unsigned OFFSET_WIDTH = $clog2(STRB_WIDTH);

    // memory size in bytes
    localparam int unsigned SIZE = 4096;

    // word-organised view of the same memory
    localparam int unsigned WORDS = SIZE / STRB_WIDTH;
    localparam int unsigned IDX_WIDTH = $clog2(WORDS);

    // bus-level payload types
    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [STRB_WIDTH-1:0] strb_t;

    // axi response field
    typedef logic [1:0] resp_t;

    // word index into the array
    typedef logic [IDX_WIDTH-1:0] idx_t;

    // only two of the four axi codes are ever produced here
    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_DECERR = 2'b11;

    // control states
    // IDLE        waiting for a request or a pause
    // WRITE_RESP  write strobe issued, then B held until bready
    // READ_WAIT   read strobe issued, array registers the word
    // READ_RESP   word captured, then R held until rready
    // PAUSED      nothing accepted while pause_req is high
    typedef enum logic [2:0] {
        IDLE,
        WRITE_RESP,
        READ_WAIT,
        READ_RESP,
        PAUSED
    } fsm_state_t;

endpackage

/* design/adam_ram_port_if.sv */
`timescale 1ns/1ps

// port between the control fsm and the word array
interface adam_ram_port_if (
    input logic clk
);

    // single-cycle strobes, never high together
    logic we;
    logic re;

    // word index, shared by reads and writes
    adam_axil_pkg::idx_t idx;

    // write payload
    adam_axil_pkg::data_t wdata;
    adam_axil_pkg::strb_t wstrb;

    // registered read word, valid the cycle after re
    adam_axil_pkg::data_t rdata;

    // fsm side
    modport ctrl (
        output we, re, idx, wdata, wstrb,
        input  rdata
    );

    // array side
    modport mem (
        input  we, re, idx, wdata, wstrb,
        output rdata
    );

endinterface

/* design/adam_axil_fsm.sv */
`timescale 1ns/1ps

module adam_axil_fsm (
    input  logic                 clk,
    input  logic                 rst_n,

    // address and write data
    input  logic                 awvalid,
    input  adam_axil_pkg::addr_t awaddr,
    input  logic                 wvalid,
    input  adam_axil_pkg::data_t wdata,
    input  adam_axil_pkg::strb_t wstrb,
    input  logic                 arvalid,
    input  adam_axil_pkg::addr_t araddr,

    // response acceptance
    input  logic                 bready,
    input  logic                 rready,

    // pause request from outside
    input  logic                 pause_req,

    output logic                 awready,
    output logic                 wready,
    output logic                 arready,
    output logic                 bvalid,
    output adam_axil_pkg::resp_t bresp,
    output logic                 rvalid,
    output adam_axil_pkg::data_t rdata,
    output adam_axil_pkg::resp_t rresp,
    output logic                 pause_ack,

    adam_ram_port_if.ctrl        ram
);

    adam_axil_pkg::fsm_state_t state;
    adam_axil_pkg::fsm_state_t state_next;

    // response code of the access in flight
    adam_axil_pkg::resp_t resp_q;

    // latched request payload
    adam_axil_pkg::idx_t  idx_q;
    adam_axil_pkg::data_t wdata_q;
    adam_axil_pkg::strb_t wstrb_q;

    logic idle_free;
    logic wr_offer;
    logic wr_go;
    logic rd_go;
    logic access_ok;

    // legal means word aligned and inside the array
    function automatic logic addr_legal(input adam_axil_pkg::addr_t addr);
        return (addr[adam_axil_pkg::OFFSET_WIDTH-1:0] == '0) &&
               (addr < adam_axil_pkg::SIZE);
    endfunction

    // drop the byte offset, keep the word number
    function automatic adam_axil_pkg::idx_t addr_to_idx(input adam_axil_pkg::addr_t addr);
        return addr[adam_axil_pkg::IDX_WIDTH+adam_axil_pkg::OFFSET_WIDTH-1:
                    adam_axil_pkg::OFFSET_WIDTH];
    endfunction

    function automatic adam_axil_pkg::resp_t resp_for(input adam_axil_pkg::addr_t addr);
        return addr_legal(addr) ? adam_axil_pkg::RESP_OKAY : adam_axil_pkg::RESP_DECERR;
    endfunction

    // a pending pause blocks new requests even in IDLE
    assign idle_free = (state == adam_axil_pkg::IDLE) && !pause_req;

    // write needs both AW and W present, and then wins over AR
    assign wr_offer = awvalid && wvalid;
    assign wr_go    = idle_free && wr_offer;
    assign rd_go    = idle_free && !wr_offer && arvalid;

    // readies follow the valids in the same cycle
    assign awready = wr_go;
    assign wready  = wr_go;
    assign arready = rd_go;

    assign pause_ack = (state == adam_axil_pkg::PAUSED);

    // one response register serves both channels
    assign bresp = resp_q;
    assign rresp = resp_q;

    // decerr accesses never reach the array
    assign access_ok = (resp_q == adam_axil_pkg::RESP_OKAY);

    // we only in the first WRITE_RESP cycle, before bvalid rises
    assign ram.we    = (state == adam_axil_pkg::WRITE_RESP) && !bvalid && access_ok;
    assign ram.re    = (state == adam_axil_pkg::READ_WAIT) && access_ok;
    assign ram.idx   = idx_q;
    assign ram.wdata = wdata_q;
    assign ram.wstrb = wstrb_q;

    always_comb begin
        state_next = state;
        case (state)
            adam_axil_pkg::IDLE: begin
                // pause checked first, it gates the readies anyway
                if (pause_req) begin
                    state_next = adam_axil_pkg::PAUSED;
                end else if (wr_go) begin
                    state_next = adam_axil_pkg::WRITE_RESP;
                end else if (rd_go) begin
                    state_next = adam_axil_pkg::READ_WAIT;
                end
            end
            adam_axil_pkg::WRITE_RESP: begin
                // leave on the B handshake
                if (bvalid && bready) begin
                    state_next = adam_axil_pkg::IDLE;
                end
            end
            adam_axil_pkg::READ_WAIT: begin
                // array output is ready after one edge
                state_next = adam_axil_pkg::READ_RESP;
            end
            adam_axil_pkg::READ_RESP: begin
                if (rvalid && rready) begin
                    state_next = adam_axil_pkg::IDLE;
                end
            end
            adam_axil_pkg::PAUSED: begin
                if (!pause_req) begin
                    state_next = adam_axil_pkg::IDLE;
                end
            end
            default: begin
                state_next = adam_axil_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= adam_axil_pkg::IDLE;
            resp_q <= adam_axil_pkg::RESP_OKAY;
        end else begin
            state <= state_next;
            // legality decided once, at address acceptance
            if (wr_go) begin
                resp_q <= resp_for(awaddr);
            end else if (rd_go) begin
                resp_q <= resp_for(araddr);
            end
        end
    end

    // response valids rise one edge after entering the response state
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bvalid <= 1'b0;
            rvalid <= 1'b0;
        end else begin
            if (bvalid && bready) begin
                bvalid <= 1'b0;
            end else if ((state == adam_axil_pkg::WRITE_RESP) && !bvalid) begin
                bvalid <= 1'b1;
            end
            if (rvalid && rready) begin
                rvalid <= 1'b0;
            end else if ((state == adam_axil_pkg::READ_RESP) && !rvalid) begin
                rvalid <= 1'b1;
            end
        end
    end

    // payload capture
    always_ff @(posedge clk) begin
        if (wr_go) begin
            idx_q   <= addr_to_idx(awaddr);
            wdata_q <= wdata;
            wstrb_q <= wstrb;
        end else if (rd_go) begin
            idx_q <= addr_to_idx(araddr);
        end
        // take the array word on the same edge rvalid rises
        if ((state == adam_axil_pkg::READ_RESP) && !rvalid) begin
            rdata <= access_ok ? ram.rdata : '0;
        end
    end

endmodule

/* design/adam_axil_storage.sv */
`timescale 1ns/1ps

module adam_axil_storage (
    input  logic          clk,
    adam_ram_port_if.mem  ram
);

    // the array itself, no reset, contents survive rst_n
    adam_axil_pkg::data_t mem [adam_axil_pkg::WORDS];

    // merged word for a strobed write
    adam_axil_pkg::data_t merged;

    // per-lane select between old and new bytes
    always_comb begin
        merged = mem[ram.idx];
        for (int b = 0; b < adam_axil_pkg::STRB_WIDTH; b++) begin
            if (ram.wstrb[b]) begin
                merged[8*b +: 8] = ram.wdata[8*b +: 8];
            end
        end
    end

    // write port
    // lanes with wstrb low keep their old value
    always_ff @(posedge clk) begin
        if (ram.we) begin
            mem[ram.idx] <= merged;
        end
    end

    // read port
    // word registered on re, held otherwise
    // fsm samples it one cycle later
    always_ff @(posedge clk) begin
        if (ram.re) begin
            ram.rdata <= mem[ram.idx];
        end
    end

endmodule

/* design/adam_axil_ram.sv */
`timescale 1ns/1ps

module adam_axil_ram (
    input  logic                 clk,
    input  logic                 rst_n,

    // write address channel
    input  logic                 awvalid,
    output logic                 awready,
    input  adam_axil_pkg::addr_t awaddr,
    // prot is not checked
    input  logic [2:0]           awprot,

    // write data channel
    input  logic                 wvalid,
    output logic                 wready,
    input  adam_axil_pkg::data_t wdata,
    input  adam_axil_pkg::strb_t wstrb,

    // write response channel
    output logic                 bvalid,
    input  logic                 bready,
    output adam_axil_pkg::resp_t bresp,

    // read address channel
    input  logic                 arvalid,
    output logic                 arready,
    input  adam_axil_pkg::addr_t araddr,
    // prot is not checked
    input  logic [2:0]           arprot,

    // read data channel
    output logic                 rvalid,
    input  logic                 rready,
    output adam_axil_pkg::data_t rdata,
    output adam_axil_pkg::resp_t rresp,

    // pause pair, level based
    input  logic                 pause_req,
    output logic                 pause_ack
);

    // fsm to array link
    adam_ram_port_if ram_if (
        .clk (clk)
    );

    // handshakes, legality, responses and pause
    adam_axil_fsm u_fsm (
        .clk       (clk),
        .rst_n     (rst_n),

        .awvalid   (awvalid),
        .awaddr    (awaddr),
        .wvalid    (wvalid),
        .wdata     (wdata),
        .wstrb     (wstrb),
        .arvalid   (arvalid),
        .araddr    (araddr),

        .bready    (bready),
        .rready    (rready),

        .pause_req (pause_req),

        .awready   (awready),
        .wready    (wready),
        .arready   (arready),
        .bvalid    (bvalid),
        .bresp     (bresp),
        .rvalid    (rvalid),
        .rdata     (rdata),
        .rresp     (rresp),
        .pause_ack (pause_ack),

        .ram       (ram_if.ctrl)
    );

    // word array
    // clocked from the port so both ends share one clock
    adam_axil_storage u_storage (
        .clk (ram_if.clk),
        .ram (ram_if.mem)
    );

endmodule

/* verif/adam_axil_ram_tb.sv */
`timescale 1ns/1ps

module adam_axil_ram_tb;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 8;

    // mid low phase where inputs and outputs have settled
    localparam int SAMPLE_DELAY = CLK_PERIOD / 4;

    localparam int BYTE_AW = $clog2(adam_axil_pkg::SIZE);

    // transaction counts per test
    localparam int PARTIALS  = 64;
    localparam int BAD_COUNT = 7;
    localparam int RANDOMS   = 200;
    localparam int TOTAL_TXN = 2 * adam_axil_pkg::WORDS + 2 * PARTIALS + 3 * BAD_COUNT
                               + RANDOMS + 2;

    // 20 cycles per transaction plus reset
    localparam int WATCHDOG_CYCLES = TOTAL_TXN * 20 + RESET_CYCLES;

    logic                 clk;
    logic                 rst_n;
    logic                 awvalid;
    logic                 awready;
    adam_axil_pkg::addr_t awaddr;
    logic [2:0]           awprot;
    logic                 wvalid;
    logic                 wready;
    adam_axil_pkg::data_t wdata;
    adam_axil_pkg::strb_t wstrb;
    logic                 bvalid;
    logic                 bready;
    adam_axil_pkg::resp_t bresp;
    logic                 arvalid;
    logic                 arready;
    adam_axil_pkg::addr_t araddr;
    logic [2:0]           arprot;
    logic                 rvalid;
    logic                 rready;
    adam_axil_pkg::data_t rdata;
    adam_axil_pkg::resp_t rresp;
    logic                 pause_req;
    logic                 pause_ack;

    // byte-wide reference memory
    logic [7:0] shadow_mem [adam_axil_pkg::SIZE];

    // expected responses in arrival order
    adam_axil_pkg::resp_t exp_b_resp [$];
    adam_axil_pkg::addr_t exp_b_addr [$];
    adam_axil_pkg::resp_t exp_r_resp [$];
    adam_axil_pkg::data_t exp_r_data [$];
    adam_axil_pkg::addr_t exp_r_addr [$];

    int   seed = 75148;
    int   pass_count;
    int   fail_count;
    int   test_errors;
    logic random_ready;

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    adam_axil_ram dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .awvalid   (awvalid),
        .awready   (awready),
        .awaddr    (awaddr),
        .awprot    (awprot),
        .wvalid    (wvalid),
        .wready    (wready),
        .wdata     (wdata),
        .wstrb     (wstrb),
        .bvalid    (bvalid),
        .bready    (bready),
        .bresp     (bresp),
        .arvalid   (arvalid),
        .arready   (arready),
        .araddr    (araddr),
        .arprot    (arprot),
        .rvalid    (rvalid),
        .rready    (rready),
        .rdata     (rdata),
        .rresp     (rresp),
        .pause_req (pause_req),
        .pause_ack (pause_ack)
    );

    // legal = word aligned and below the memory size
    function automatic adam_axil_pkg::resp_t expect_resp(input adam_axil_pkg::addr_t addr);
        if ((addr[1:0] != 2'b00) || (addr >= adam_axil_pkg::SIZE)) begin
            return adam_axil_pkg::RESP_DECERR;
        end
        return adam_axil_pkg::RESP_OKAY;
    endfunction

    // little endian word from the shadow or zero on decerr
    function automatic adam_axil_pkg::data_t expect_rdata(input adam_axil_pkg::addr_t addr);
        adam_axil_pkg::data_t word;
        word = '0;
        if (expect_resp(addr) == adam_axil_pkg::RESP_OKAY) begin
            for (int b = 0; b < adam_axil_pkg::STRB_WIDTH; b++) begin
                word[8*b +: 8] = shadow_mem[BYTE_AW'(addr + adam_axil_pkg::addr_t'(b))];
            end
        end
        return word;
    endfunction

    function automatic void shadow_write(input adam_axil_pkg::addr_t addr,
                                         input adam_axil_pkg::data_t data,
                                         input adam_axil_pkg::strb_t strb);
        if (expect_resp(addr) == adam_axil_pkg::RESP_OKAY) begin
            for (int b = 0; b < adam_axil_pkg::STRB_WIDTH; b++) begin
                if (strb[b]) begin
                    shadow_mem[BYTE_AW'(addr + adam_axil_pkg::addr_t'(b))] = data[8*b +: 8];
                end
            end
        end
    endfunction

    // coin flip in test 4 and always ready elsewhere
    function automatic logic pick_ready();
        int r;
        r = $random(seed);
        if (random_ready) begin
            return r[0];
        end
        return 1'b1;
    endfunction

    // misaligned ones first and then out of range
    function automatic adam_axil_pkg::addr_t bad_addr(input int k);
        case (k)
            0: return 32'h0000_0001;
            1: return 32'h0000_0002;
            2: return 32'h0000_0003;
            3: return adam_axil_pkg::SIZE;
            4: return adam_axil_pkg::SIZE + 1;
            5: return adam_axil_pkg::SIZE + 4;
            default: return 32'hFFFF_FFFC;
        endcase
    endfunction

    task automatic check_resp(input adam_axil_pkg::resp_t got, input adam_axil_pkg::resp_t exp,
                              input string msg);
        if (got !== exp) begin
            $display("FAILED %0t: %s, got %0d expected %0d", $time, msg, got, exp);
            fail_count++;
            test_errors++;
        end else begin
            pass_count++;
        end
    endtask

    task automatic check_data(input adam_axil_pkg::data_t got, input adam_axil_pkg::data_t exp,
                              input string msg);
        if (got !== exp) begin
            $display("FAILED %0t: %s, got %h expected %h", $time, msg, got, exp);
            fail_count++;
            test_errors++;
        end else begin
            pass_count++;
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string msg);
        if (got !== exp) begin
            $display("FAILED %0t: %s, got %b expected %b", $time, msg, got, exp);
            fail_count++;
            test_errors++;
        end else begin
            pass_count++;
        end
    endtask

    // AW and W offered together at a falling edge
    task automatic offer_write(input adam_axil_pkg::addr_t addr,
                               input adam_axil_pkg::data_t data,
                               input adam_axil_pkg::strb_t strb);
        @(negedge clk);
        awvalid = 1'b1;
        awaddr  = addr;
        wvalid  = 1'b1;
        wdata   = data;
        wstrb   = strb;
        exp_b_resp.push_back(expect_resp(addr));
        exp_b_addr.push_back(addr);
        shadow_write(addr, data, strb);
    endtask

    // called at a falling edge
    task automatic finish_write();
        logic done;
        #(SAMPLE_DELAY);
        while (!(awready && wready)) begin
            @(negedge clk);
            #(SAMPLE_DELAY);
        end
        // beats taken on the rising edge just passed
        @(negedge clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        bready  = pick_ready();
        done = 1'b0;
        while (!done) begin
            #(SAMPLE_DELAY);
            done = bvalid && bready;
            @(negedge clk);
            if (!done) begin
                bready = pick_ready();
            end
        end
    endtask

    task automatic offer_read(input adam_axil_pkg::addr_t addr);
        @(negedge clk);
        arvalid = 1'b1;
        araddr  = addr;
        exp_r_resp.push_back(expect_resp(addr));
        exp_r_data.push_back(expect_rdata(addr));
        exp_r_addr.push_back(addr);
    endtask

    task automatic finish_read();
        logic done;
        #(SAMPLE_DELAY);
        while (!arready) begin
            @(negedge clk);
            #(SAMPLE_DELAY);
        end
        @(negedge clk);
        arvalid = 1'b0;
        rready  = pick_ready();
        done = 1'b0;
        while (!done) begin
            #(SAMPLE_DELAY);
            done = rvalid && rready;
            @(negedge clk);
            if (!done) begin
                rready = pick_ready();
            end
        end
    endtask

    task automatic write_beat(input adam_axil_pkg::addr_t addr,
                              input adam_axil_pkg::data_t data,
                              input adam_axil_pkg::strb_t strb);
        offer_write(addr, data, strb);
        finish_write();
    endtask

    task automatic read_beat(input adam_axil_pkg::addr_t addr);
        offer_read(addr);
        finish_read();
    endtask

    task automatic report_test(input int num, input string name);
        @(negedge clk);
        $display("test %0d %s: %0d errors", num, name, test_errors);
        test_errors = 0;
    endtask

    // one sample per cycle
    // a handshake seen here transfers at the next rising edge
    initial begin : compare
        adam_axil_pkg::resp_t e_resp;
        adam_axil_pkg::data_t e_data;
        adam_axil_pkg::addr_t e_addr;
        forever begin
            @(negedge clk);
            #(SAMPLE_DELAY);
            if (rst_n && bvalid && bready) begin
                if (exp_b_resp.size() == 0) begin
                    $display("write response at %0t with no write outstanding", $time);
                    fail_count++;
                    test_errors++;
                end else begin
                    e_resp = exp_b_resp.pop_front();
                    e_addr = exp_b_addr.pop_front();
                    check_resp(bresp, e_resp, $sformatf("bresp for addr %h", e_addr));
                end
            end
            if (rst_n && rvalid && rready) begin
                if (exp_r_resp.size() == 0) begin
                    $display("read response at %0t with no read outstanding", $time);
                    fail_count++;
                    test_errors++;
                end else begin
                    e_resp = exp_r_resp.pop_front();
                    e_data = exp_r_data.pop_front();
                    e_addr = exp_r_addr.pop_front();
                    check_resp(rresp, e_resp, $sformatf("rresp for addr %h", e_addr));
                    check_data(rdata, e_data, $sformatf("rdata for addr %h", e_addr));
                end
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: simulation did not finish");
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin : main
        adam_axil_pkg::addr_t addr;
        adam_axil_pkg::data_t data;
        adam_axil_pkg::strb_t strb;
        int                   kind;
        pass_count   = 0;
        fail_count   = 0;
        test_errors  = 0;
        random_ready = 1'b0;
        rst_n     = 1'b0;
        awvalid   = 1'b0;
        awaddr    = '0;
        awprot    = 3'b000;
        wvalid    = 1'b0;
        wdata     = '0;
        wstrb     = '0;
        bready    = 1'b1;
        arvalid   = 1'b0;
        araddr    = '0;
        arprot    = 3'b000;
        rready    = 1'b1;
        pause_req = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // test 1 checks idle outputs and then fills and reads back every word
        #(SAMPLE_DELAY);
        check_flag(awready, 1'b0, "awready after reset");
        check_flag(wready, 1'b0, "wready after reset");
        check_flag(arready, 1'b0, "arready after reset");
        check_flag(bvalid, 1'b0, "bvalid after reset");
        check_flag(rvalid, 1'b0, "rvalid after reset");
        check_flag(pause_ack, 1'b0, "pause_ack after reset");
        for (int i = 0; i < int'(adam_axil_pkg::WORDS); i++) begin
            write_beat(adam_axil_pkg::addr_t'(i * 4), adam_axil_pkg::data_t'(i * 4), 4'hF);
        end
        for (int i = 0; i < int'(adam_axil_pkg::WORDS); i++) begin
            read_beat(adam_axil_pkg::addr_t'(i * 4));
        end
        report_test(1, "reset and full fill");

        // test 2 writes random strobes to random words
        for (int i = 0; i < PARTIALS; i++) begin
            addr = {$random(seed)} % adam_axil_pkg::SIZE;
            addr[1:0] = 2'b00;
            data = $random(seed);
            strb = adam_axil_pkg::strb_t'($random(seed));
            write_beat(addr, data, strb);
            read_beat(addr);
        end
        report_test(2, "partial strobes");

        // test 3 expects decerr on both channels
        // and neighbouring words untouched
        for (int k = 0; k < BAD_COUNT; k++) begin
            write_beat(bad_addr(k), 32'hDEAD_BEEF, 4'hF);
            read_beat(bad_addr(k));
        end
        for (int k = 0; k < BAD_COUNT; k++) begin
            addr = bad_addr(k);
            if (addr < adam_axil_pkg::SIZE) begin
                addr[1:0] = 2'b00;
            end else begin
                addr = adam_axil_pkg::addr_t'(adam_axil_pkg::SIZE - 4);
            end
            read_beat(addr);
        end
        report_test(3, "illegal addresses");

        // test 4 sends mixed traffic with random back-pressure
        random_ready = 1'b1;
        for (int i = 0; i < RANDOMS; i++) begin
            addr = {$random(seed)} % (2 * adam_axil_pkg::SIZE);
            if ($random(seed) & 1) begin
                addr[1:0] = 2'b00;
            end
            kind = $random(seed) & 1;
            if (kind == 1) begin
                data = $random(seed);
                strb = adam_axil_pkg::strb_t'($random(seed));
                write_beat(addr, data, strb);
            end else begin
                read_beat(addr);
            end
        end
        random_ready = 1'b0;
        @(negedge clk);
        bready = 1'b1;
        rready = 1'b1;
        report_test(4, "random mixed traffic");

        // test 5 offers a write while paused
        @(negedge clk);
        pause_req = 1'b1;
        #(SAMPLE_DELAY);
        while (!pause_ack) begin
            @(negedge clk);
            #(SAMPLE_DELAY);
        end
        addr = 32'h0000_0100;
        offer_write(addr, 32'hA5C3_0F96, 4'hF);
        repeat (5) begin
            #(SAMPLE_DELAY);
            check_flag(awready, 1'b0, "awready while paused");
            check_flag(wready, 1'b0, "wready while paused");
            check_flag(pause_ack, 1'b1, "pause_ack held");
            @(negedge clk);
        end
        pause_req = 1'b0;
        fork
            finish_write();
            begin
                // one edge after release
                @(negedge clk);
                #(SAMPLE_DELAY);
                check_flag(pause_ack, 1'b0, "pause_ack after release");
            end
        join
        read_beat(addr);
        report_test(5, "pause handling");

        if ((exp_b_resp.size() != 0) || (exp_r_resp.size() != 0)) begin
            $display("responses missing: %0d writes and %0d reads never answered",
                     exp_b_resp.size(), exp_r_resp.size());
            fail_count++;
        end
        $display("checks passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* flist.f */
design/adam_axil_pkg.sv
design/adam_ram_port_if.sv
design/adam_axil_fsm.sv
design/adam_axil_storage.sv
design/adam_axil_ram.sv
verif/adam_axil_ram_tb.sv

/* run.sh */
#!/bin/sh

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module adam_axil_ram_tb -f flist.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vadam_axil_ram_tb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "TEST RESULT: PASS"; then
    exit 0
fi
echo "pass line not found in simulation output"
exit 1
